// ==== common/mips_pkg.sv ====
package mips_pkg;

    // Datapath sizes
    localparam int data_width      = 32;
    localparam int reg_addr_width  = 5;
    localparam int shamt_width     = 5;
    localparam int imem_depth      = 256;
    localparam int dmem_depth      = 256;
    localparam int imem_addr_width = $clog2(imem_depth);
    localparam int dmem_addr_width = $clog2(dmem_depth);

    ////////////////////////////////////////
    // Opcodes and function codes
    ////////////////////////////////////////

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_lui
    } alu_op_t;

    // Where an EX operand comes from
    typedef enum logic [1:0] {
        fwd_idex, fwd_exmem, fwd_memwb
    } fwd_sel_t;

    // One instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0]                opcode;
            logic [reg_addr_width-1:0] rs;
            logic [reg_addr_width-1:0] rt;
            logic [reg_addr_width-1:0] rd;
            logic [shamt_width-1:0]    shamt;
            logic [5:0]                funct;
        } rtype_fields;
        struct packed {
            logic [5:0]                opcode;
            logic [reg_addr_width-1:0] rs;
            logic [reg_addr_width-1:0] rt;
            logic [15:0]               imm;
        } itype_fields;
    } instr_t;

endpackage

// ==== fetch/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage
    import mips_pkg::*;
(
    input  logic                       ui_clk_from_ddr,
    input  logic                       reset,
    input  logic                       pc_stall,
    input  logic                       ifid_stall,
    input  logic                       ifid_flush,
    input  logic                       branch_taken,
    input  logic [data_width-1:0]      branch_target,
    input  logic                       imem_load_en,
    input  logic [imem_addr_width-1:0] imem_load_addr,
    input  logic [data_width-1:0]      imem_load_data,
    output logic [data_width-1:0]      ifid_pc4,
    output instr_t                     ifid_instr
);

    logic [data_width-1:0] pc;
    logic [data_width-1:0] pc4;
    logic [data_width-1:0] imem [imem_depth];

    assign pc4 = pc + data_width'(4);

    // Taken branch has priority over a load-use hold
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!pc_stall) begin
            pc <= pc4;
        end
    end

    // Program load port
    always_ff @(posedge ui_clk_from_ddr) begin
        if (imem_load_en) begin
            imem[imem_load_addr] <= imem_load_data;
        end
    end

    // IF/ID register
    // Flushed slot holds the all-zero word (sll $0 as no-op)
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset || ifid_flush) begin
            ifid_instr <= '0;
            ifid_pc4   <= '0;
        end else if (!ifid_stall) begin
            ifid_instr <= imem[pc[imem_addr_width+1:2]];
            ifid_pc4   <= pc4;
        end
    end

    // Program memory is only written while the core is held in reset
    assert property (@(posedge ui_clk_from_ddr) imem_load_en |-> reset)
        else $error("imem load while core running");

endmodule

// ==== decode/gpr_file.sv ====
`timescale 1ns/1ns

module gpr_file
    import mips_pkg::*;
(
    input  logic                      ui_clk_from_ddr,
    input  logic                      reset,
    input  logic [reg_addr_width-1:0] rs_addr,
    input  logic [reg_addr_width-1:0] rt_addr,
    input  logic [reg_addr_width-1:0] rd_addr,
    input  logic [data_width-1:0]     rd_data,
    input  logic                      write,
    output logic [data_width-1:0]     rs_data,
    output logic [data_width-1:0]     rt_data
);

    logic [data_width-1:0] regs [2**reg_addr_width];

    // Register zero is never written
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Write in the same cycle is passed straight to the reader
    assign rs_data = (rs_addr == '0) ? '0 :
                     (write && rd_addr == rs_addr) ? rd_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (write && rd_addr == rt_addr) ? rd_data : regs[rt_addr];

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
    import mips_pkg::*;
(
    input  logic                       ui_clk_from_ddr,
    input  logic                       reset,
    input  instr_t                     ifid_instr,
    input  logic [data_width-1:0]      ifid_pc4,
    input  logic                       idex_flush,
    input  logic [data_width-1:0]      wb_data,
    input  logic [reg_addr_width-1:0]  memwb_rd_addr,
    input  logic                       memwb_reg_w,
    output logic [data_width-1:0]      idex_a,
    output logic [data_width-1:0]      idex_b,
    output logic [data_width-1:0]      idex_imm,
    output logic [shamt_width-1:0]     idex_shamt,
    output logic [reg_addr_width-1:0]  idex_rs_addr,
    output logic [reg_addr_width-1:0]  idex_rt_addr,
    output logic [reg_addr_width-1:0]  idex_rd_addr,
    output alu_op_t                    idex_alu_op,
    output logic                       idex_b_is_imm,
    output logic                       idex_mem_r,
    output logic                       idex_mem_w,
    output logic                       idex_reg_w,
    output logic                       idex_branch_eq,
    output logic                       idex_branch_ne,
    output logic [data_width-1:0]      idex_pc4
);

    logic [data_width-1:0]     rs_data;
    logic [data_width-1:0]     rt_data;
    logic [data_width-1:0]     imm_ext;
    logic [reg_addr_width-1:0] dest_addr;
    alu_op_t                   alu_op;
    logic                      b_is_imm;
    logic                      mem_r;
    logic                      mem_w;
    logic                      reg_w;
    logic                      branch_eq;
    logic                      branch_ne;
    logic                      sign_ext;
    logic                      use_rd;

    gpr_file gpr_file_inst (
        .ui_clk_from_ddr ( ui_clk_from_ddr                ),
        .reset           ( reset                          ),
        .rs_addr         ( ifid_instr.itype_fields.rs     ),
        .rt_addr         ( ifid_instr.itype_fields.rt     ),
        .rd_addr         ( memwb_rd_addr                  ),
        .rd_data         ( wb_data                        ),
        .write           ( memwb_reg_w                    ),
        .rs_data         ( rs_data                        ),
        .rt_data         ( rt_data                        )
    );

    ////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////

    always_comb begin
        alu_op    = alu_add;
        b_is_imm  = 1'b0;
        mem_r     = 1'b0;
        mem_w     = 1'b0;
        reg_w     = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        sign_ext  = 1'b0;
        use_rd    = 1'b0;
        case (ifid_instr.rtype_fields.opcode)
            op_rtype: begin
                reg_w  = 1'b1;
                use_rd = 1'b1;
                case (ifid_instr.rtype_fields.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    default: reg_w  = 1'b0;
                endcase
            end
            op_addiu: begin
                reg_w    = 1'b1;
                b_is_imm = 1'b1;
                sign_ext = 1'b1;
            end
            op_andi: begin
                alu_op   = alu_and;
                reg_w    = 1'b1;
                b_is_imm = 1'b1;
            end
            op_ori: begin
                alu_op   = alu_or;
                reg_w    = 1'b1;
                b_is_imm = 1'b1;
            end
            op_lui: begin
                alu_op   = alu_lui;
                reg_w    = 1'b1;
                b_is_imm = 1'b1;
            end
            op_lw: begin
                mem_r    = 1'b1;
                reg_w    = 1'b1;
                b_is_imm = 1'b1;
                sign_ext = 1'b1;
            end
            op_sw: begin
                mem_w    = 1'b1;
                b_is_imm = 1'b1;
                sign_ext = 1'b1;
            end
            op_beq: begin
                branch_eq = 1'b1;
                sign_ext  = 1'b1;
            end
            op_bne: begin
                branch_ne = 1'b1;
                sign_ext  = 1'b1;
            end
            default: reg_w = 1'b0;
        endcase
    end

    assign imm_ext = sign_ext ?
                     {{(data_width-16){ifid_instr.itype_fields.imm[15]}},
                      ifid_instr.itype_fields.imm} :
                     {{(data_width-16){1'b0}}, ifid_instr.itype_fields.imm};

    // rd for R-type, rt for everything else
    assign dest_addr = use_rd ? ifid_instr.rtype_fields.rd : ifid_instr.itype_fields.rt;

    // ID/EX control bits clear to a bubble on reset or flush
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset || idex_flush) begin
            idex_mem_r     <= 1'b0;
            idex_mem_w     <= 1'b0;
            idex_reg_w     <= 1'b0;
            idex_branch_eq <= 1'b0;
            idex_branch_ne <= 1'b0;
        end else begin
            idex_mem_r     <= mem_r;
            idex_mem_w     <= mem_w;
            idex_reg_w     <= reg_w;
            idex_branch_eq <= branch_eq;
            idex_branch_ne <= branch_ne;
        end
    end

    // ID/EX payload
    always_ff @(posedge ui_clk_from_ddr) begin
        idex_a        <= rs_data;
        idex_b        <= rt_data;
        idex_imm      <= imm_ext;
        idex_shamt    <= ifid_instr.rtype_fields.shamt;
        idex_rs_addr  <= ifid_instr.itype_fields.rs;
        idex_rt_addr  <= ifid_instr.itype_fields.rt;
        idex_rd_addr  <= dest_addr;
        idex_alu_op   <= alu_op;
        idex_b_is_imm <= b_is_imm;
        idex_pc4      <= ifid_pc4;
    end

    assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
                     !(idex_mem_r && idex_mem_w))
        else $error("load and store decoded together");

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage
    import mips_pkg::*;
(
    input  logic                      ui_clk_from_ddr,
    input  logic                      reset,
    input  logic [data_width-1:0]     idex_a,
    input  logic [data_width-1:0]     idex_b,
    input  logic [data_width-1:0]     idex_imm,
    input  logic [shamt_width-1:0]    idex_shamt,
    input  logic [reg_addr_width-1:0] idex_rs_addr,
    input  logic [reg_addr_width-1:0] idex_rt_addr,
    input  logic [reg_addr_width-1:0] idex_rd_addr,
    input  alu_op_t                   idex_alu_op,
    input  logic                      idex_b_is_imm,
    input  logic                      idex_mem_r,
    input  logic                      idex_mem_w,
    input  logic                      idex_reg_w,
    input  logic                      idex_branch_eq,
    input  logic                      idex_branch_ne,
    input  logic [data_width-1:0]     idex_pc4,
    input  fwd_sel_t                  fwd_a_sel,
    input  fwd_sel_t                  fwd_b_sel,
    input  logic [data_width-1:0]     wb_data,
    output logic                      branch_taken,
    output logic [data_width-1:0]     branch_target,
    output logic [data_width-1:0]     exmem_res,
    output logic [data_width-1:0]     exmem_rt_data,
    output logic [reg_addr_width-1:0] exmem_rd_addr,
    output logic                      exmem_reg_w,
    output logic                      exmem_mem_r,
    output logic                      exmem_mem_w
);

    logic [data_width-1:0] op_a;
    logic [data_width-1:0] fwd_b;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] alu_res;

    function automatic logic [data_width-1:0] fwd_mux(
        input fwd_sel_t              sel,
        input logic [data_width-1:0] from_idex,
        input logic [data_width-1:0] from_exmem,
        input logic [data_width-1:0] from_memwb
    );
        case (sel)
            fwd_exmem: return from_exmem;
            fwd_memwb: return from_memwb;
            default:   return from_idex;
        endcase
    endfunction

    ////////////////////////////////////////
    // Operands and ALU
    ////////////////////////////////////////

    assign op_a  = fwd_mux(fwd_a_sel, idex_a, exmem_res, wb_data);
    assign fwd_b = fwd_mux(fwd_b_sel, idex_b, exmem_res, wb_data);
    assign op_b  = idex_b_is_imm ? idex_imm : fwd_b;

    always_comb begin
        case (idex_alu_op)
            alu_sub: alu_res = op_a - op_b;
            alu_and: alu_res = op_a & op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_xor: alu_res = op_a ^ op_b;
            alu_slt: alu_res = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll: alu_res = op_b << idex_shamt;
            alu_srl: alu_res = op_b >> idex_shamt;
            alu_lui: alu_res = {op_b[15:0], 16'b0};
            default: alu_res = op_a + op_b;
        endcase
    end

    // Branch resolution
    // Target is pc4 plus the word offset
    assign branch_taken  = (idex_branch_eq && op_a == fwd_b) ||
                           (idex_branch_ne && op_a != fwd_b);
    assign branch_target = idex_pc4 + {idex_imm[data_width-3:0], 2'b00};

    // EX/MEM
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            exmem_reg_w <= 1'b0;
            exmem_mem_r <= 1'b0;
            exmem_mem_w <= 1'b0;
        end else begin
            exmem_reg_w <= idex_reg_w;
            exmem_mem_r <= idex_mem_r;
            exmem_mem_w <= idex_mem_w;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        exmem_res     <= alu_res;
        exmem_rt_data <= fwd_b;
        exmem_rd_addr <= idex_rd_addr;
    end

    assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
                     branch_taken |-> (idex_branch_eq || idex_branch_ne))
        else $error("branch taken without a branch in EX");

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit
    import mips_pkg::*;
(
    input  logic [reg_addr_width-1:0] ifid_rs_addr,
    input  logic [reg_addr_width-1:0] ifid_rt_addr,
    input  logic [reg_addr_width-1:0] idex_rd_addr,
    input  logic                      idex_mem_r,
    input  logic [reg_addr_width-1:0] idex_rs_addr,
    input  logic [reg_addr_width-1:0] idex_rt_addr,
    input  logic [reg_addr_width-1:0] exmem_rd_addr,
    input  logic                      exmem_reg_w,
    input  logic [reg_addr_width-1:0] memwb_rd_addr,
    input  logic                      memwb_reg_w,
    input  logic                      branch_taken,
    output logic                      pc_stall,
    output logic                      ifid_stall,
    output logic                      idex_flush,
    output logic                      ifid_flush,
    output fwd_sel_t                  fwd_a_sel,
    output fwd_sel_t                  fwd_b_sel
);

    logic load_use;

    // Newest producer wins
    // Register zero never forwards
    function automatic fwd_sel_t fwd_pick(
        input logic [reg_addr_width-1:0] src,
        input logic [reg_addr_width-1:0] ex_rd,
        input logic                      ex_w,
        input logic [reg_addr_width-1:0] wb_rd,
        input logic                      wb_w
    );
        return (src == '0) ? fwd_idex :
               (ex_w && ex_rd == src) ? fwd_exmem :
               (wb_w && wb_rd == src) ? fwd_memwb : fwd_idex;
    endfunction

    assign fwd_a_sel = fwd_pick(idex_rs_addr, exmem_rd_addr, exmem_reg_w,
                                memwb_rd_addr, memwb_reg_w);
    assign fwd_b_sel = fwd_pick(idex_rt_addr, exmem_rd_addr, exmem_reg_w,
                                memwb_rd_addr, memwb_reg_w);

    // Load in EX feeding the instruction in ID
    assign load_use = idex_mem_r && idex_rd_addr != '0 &&
                      (idex_rd_addr == ifid_rs_addr || idex_rd_addr == ifid_rt_addr);

    assign pc_stall   = load_use;
    assign ifid_stall = load_use;
    assign idex_flush = load_use || branch_taken;
    assign ifid_flush = branch_taken;

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage
    import mips_pkg::*;
(
    input  logic                      ui_clk_from_ddr,
    input  logic                      reset,
    input  logic [data_width-1:0]     exmem_res,
    input  logic [data_width-1:0]     exmem_rt_data,
    input  logic [reg_addr_width-1:0] exmem_rd_addr,
    input  logic                      exmem_reg_w,
    input  logic                      exmem_mem_r,
    input  logic                      exmem_mem_w,
    output logic                      store_valid,
    output logic [data_width-1:0]     store_addr,
    output logic [data_width-1:0]     store_data,
    output logic                      memwb_mem_r,
    output logic [data_width-1:0]     memwb_mem_data,
    output logic [data_width-1:0]     memwb_ex_data,
    output logic [reg_addr_width-1:0] memwb_rd_addr,
    output logic                      memwb_reg_w
);

    logic [data_width-1:0]      dmem [dmem_depth];
    logic [dmem_addr_width-1:0] word_addr;

    assign word_addr = exmem_res[dmem_addr_width+1:2];

    always_ff @(posedge ui_clk_from_ddr) begin
        if (exmem_mem_w) begin
            dmem[word_addr] <= exmem_rt_data;
        end
    end

    // Every store is also shown outside
    assign store_valid = exmem_mem_w;
    assign store_addr  = exmem_res;
    assign store_data  = exmem_rt_data;

    // MEM/WB
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            memwb_mem_r <= 1'b0;
            memwb_reg_w <= 1'b0;
        end else begin
            memwb_mem_r <= exmem_mem_r;
            memwb_reg_w <= exmem_reg_w;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        memwb_mem_data <= dmem[word_addr];
        memwb_ex_data  <= exmem_res;
        memwb_rd_addr  <= exmem_rd_addr;
    end

    assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
                     exmem_mem_w |-> exmem_res[1:0] == 2'b00)
        else $error("unaligned store address %h", exmem_res);

endmodule

// ==== hdl/pipeline_top.sv ====
`timescale 1ns/1ns

module pipeline_top
    import mips_pkg::*;
(
    input  logic                       ui_clk_from_ddr,
    input  logic                       reset,
    input  logic                       imem_load_en,
    input  logic [imem_addr_width-1:0] imem_load_addr,
    input  logic [data_width-1:0]      imem_load_data,
    output logic                       store_valid,
    output logic [data_width-1:0]      store_addr,
    output logic [data_width-1:0]      store_data
);

    // IF/ID
    logic [data_width-1:0]     ifid_pc4;
    instr_t                    ifid_instr;
    logic [reg_addr_width-1:0] ifid_rs_addr;
    logic [reg_addr_width-1:0] ifid_rt_addr;

    // ID/EX
    logic [data_width-1:0]     idex_a;
    logic [data_width-1:0]     idex_b;
    logic [data_width-1:0]     idex_imm;
    logic [data_width-1:0]     idex_pc4;
    logic [shamt_width-1:0]    idex_shamt;
    logic [reg_addr_width-1:0] idex_rs_addr;
    logic [reg_addr_width-1:0] idex_rt_addr;
    logic [reg_addr_width-1:0] idex_rd_addr;
    alu_op_t                   idex_alu_op;
    logic                      idex_b_is_imm;
    logic                      idex_mem_r;
    logic                      idex_mem_w;
    logic                      idex_reg_w;
    logic                      idex_branch_eq;
    logic                      idex_branch_ne;

    // EX/MEM and branch resolution
    logic                      branch_taken;
    logic [data_width-1:0]     branch_target;
    logic [data_width-1:0]     exmem_res;
    logic [data_width-1:0]     exmem_rt_data;
    logic [reg_addr_width-1:0] exmem_rd_addr;
    logic                      exmem_reg_w;
    logic                      exmem_mem_r;
    logic                      exmem_mem_w;

    // MEM/WB and writeback
    logic                      memwb_mem_r;
    logic [data_width-1:0]     memwb_mem_data;
    logic [data_width-1:0]     memwb_ex_data;
    logic [reg_addr_width-1:0] memwb_rd_addr;
    logic                      memwb_reg_w;
    logic [data_width-1:0]     wb_data;

    // Hazard controls
    logic                      pc_stall;
    logic                      ifid_stall;
    logic                      ifid_flush;
    logic                      idex_flush;
    fwd_sel_t                  fwd_a_sel;
    fwd_sel_t                  fwd_b_sel;

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////

    fetch_stage   fetch_stage_inst   (.*);
    decode_stage  decode_stage_inst  (.*);
    execute_stage execute_stage_inst (.*);
    mem_stage     mem_stage_inst     (.*);

    // Source registers of the instruction in ID, for the load-use check
    assign ifid_rs_addr = ifid_instr.itype_fields.rs;
    assign ifid_rt_addr = ifid_instr.itype_fields.rt;

    hazard_unit hazard_unit_inst (.*);

    // Writeback select
    assign wb_data = memwb_mem_r ? memwb_mem_data : memwb_ex_data;

endmodule

// ==== tb/pipeline_checker.sv ====
`timescale 1ns/1ns

module pipeline_checker
    import mips_pkg::*;
(
    input  logic                  ui_clk_from_ddr,
    input  logic                  reset,
    input  logic                  store_valid,
    input  logic [data_width-1:0] store_addr,
    input  logic [data_width-1:0] store_data
);

    logic [data_width-1:0] want_addr_q [$];
    logic [data_width-1:0] want_data_q [$];
    int                    seen_count  = 0;
    int                    error_count = 0;

    task automatic clear_expected();
        want_addr_q.delete();
        want_data_q.delete();
    endtask

    task automatic expect_store(input logic [data_width-1:0] addr,
                                input logic [data_width-1:0] data);
        want_addr_q.push_back(addr);
        want_data_q.push_back(data);
    endtask

    // Each store on the port is matched against the oldest expected one
    always @(posedge ui_clk_from_ddr) begin : compare
        logic [data_width-1:0] want_addr;
        logic [data_width-1:0] want_data;
        int                    errs_now;
        errs_now = 0;
        if (store_valid) begin
            if (reset) begin
                $display("store to %h seen at %0t while reset is high", store_addr, $time);
                errs_now = errs_now + 1;
            end else if (want_addr_q.size() == 0) begin
                $display("unexpected extra store to %h at %0t", store_addr, $time);
                errs_now = errs_now + 1;
            end else begin
                want_addr = want_addr_q.pop_front();
                want_data = want_data_q.pop_front();
                if (store_addr !== want_addr) begin
                    $display("mismatch at %0t: store_addr expected %h got %h",
                             $time, want_addr, store_addr);
                    errs_now = errs_now + 1;
                end
                if (store_data !== want_data) begin
                    $display("mismatch at %0t: store_data expected %h got %h",
                             $time, want_data, store_data);
                    errs_now = errs_now + 1;
                end
            end
            seen_count <= seen_count + 1;
        end
        error_count <= error_count + errs_now;
    end

endmodule

// ==== tb/pipeline_tb.sv ====
`timescale 1ns/1ns

module pipeline_tb
    import mips_pkg::*;
();

    localparam int clk_half    = 4;
    localparam int reset_hold  = 4;
    localparam int store_limit = 500;
    localparam int max_tests   = 16;
    localparam int max_words   = 256;
    localparam int max_stores  = 64;

    logic                       ui_clk_from_ddr = 1'b0;
    logic                       reset;
    logic                       imem_load_en;
    logic [imem_addr_width-1:0] imem_load_addr;
    logic [data_width-1:0]      imem_load_data;
    logic                       store_valid;
    logic [data_width-1:0]      store_addr;
    logic [data_width-1:0]      store_data;

    // Parsed contents of the tests file
    string                      test_name [max_tests];
    int                         test_num [max_tests];
    int                         prog_first [max_tests];
    int                         prog_len [max_tests];
    int                         exp_first [max_tests];
    int                         exp_len [max_tests];
    logic [imem_addr_width-1:0] word_addr [max_words];
    logic [data_width-1:0]      word_data [max_words];
    logic [data_width-1:0]      exp_addr [max_stores];
    logic [data_width-1:0]      exp_data [max_stores];
    int                         n_tests  = 0;
    int                         n_words  = 0;
    int                         n_stores = 0;
    int                         tb_errors    = 0;
    int                         failed_tests = 0;

    always #clk_half ui_clk_from_ddr = ~ui_clk_from_ddr;

    pipeline_top pipeline_top_inst (.*);

    pipeline_checker checker_inst (.*);

    ////////////////////////////////////////
    // Tests file parsing
    ////////////////////////////////////////

    task automatic read_tests();
        int                    fd;
        int                    r;
        string                 line;
        string                 kw;
        string                 name;
        int                    num;
        logic [data_width-1:0] a;
        logic [data_width-1:0] d;
        fd = $fopen("tb/pipeline_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/pipeline_tests.txt");
            tb_errors = tb_errors + 1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r == 0 || line.len() < 3 || line.substr(0, 0) == "#") begin
                continue;
            end
            r = $sscanf(line, "%s", kw);
            if (kw == "test" && n_tests < max_tests) begin
                r = $sscanf(line, "%s %d %s", kw, num, name);
                test_num[n_tests]   = num;
                test_name[n_tests]  = name;
                prog_first[n_tests] = n_words;
                prog_len[n_tests]   = 0;
                exp_first[n_tests]  = n_stores;
                exp_len[n_tests]    = 0;
                n_tests = n_tests + 1;
            end else if (kw == "prog" && n_tests > 0 && n_words < max_words) begin
                r = $sscanf(line, "%s %h %h", kw, a, d);
                word_addr[n_words] = a[imem_addr_width-1:0];
                word_data[n_words] = d;
                n_words = n_words + 1;
                prog_len[n_tests-1] = prog_len[n_tests-1] + 1;
            end else if (kw == "store" && n_tests > 0 && n_stores < max_stores) begin
                r = $sscanf(line, "%s %h %h", kw, a, d);
                exp_addr[n_stores] = a;
                exp_data[n_stores] = d;
                n_stores = n_stores + 1;
                exp_len[n_tests-1] = exp_len[n_tests-1] + 1;
            end else begin
                $display("bad line in tests file: %s", line);
                tb_errors = tb_errors + 1;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // Running one test
    ////////////////////////////////////////

    task automatic run_test(input int t);
        int cycles;
        int errs_before;
        int errs;
        int target;
        errs_before = tb_errors + checker_inst.error_count;
        @(posedge ui_clk_from_ddr);
        reset <= 1'b1;
        repeat (reset_hold) @(posedge ui_clk_from_ddr);
        checker_inst.clear_expected();
        for (int i = 0; i < exp_len[t]; i++) begin
            checker_inst.expect_store(exp_addr[exp_first[t]+i], exp_data[exp_first[t]+i]);
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge ui_clk_from_ddr);
            imem_load_en   <= 1'b1;
            imem_load_addr <= word_addr[prog_first[t]+i];
            imem_load_data <= word_data[prog_first[t]+i];
        end
        @(posedge ui_clk_from_ddr);
        imem_load_en <= 1'b0;
        @(posedge ui_clk_from_ddr);
        reset  <= 1'b0;
        target = checker_inst.seen_count + exp_len[t];
        cycles = 0;
        while (checker_inst.seen_count < target && cycles < store_limit) begin
            @(posedge ui_clk_from_ddr);
            cycles = cycles + 1;
        end
        if (checker_inst.seen_count < target) begin
            $display("test %0d %s timed out waiting for its stores", test_num[t], test_name[t]);
            tb_errors = tb_errors + 1;
        end
        // Give any stray store time to show up
        repeat (8) @(posedge ui_clk_from_ddr);
        errs = tb_errors + checker_inst.error_count - errs_before;
        if (errs != 0) begin
            failed_tests = failed_tests + 1;
        end
        $display("test %0d %s: %s, %0d errors", test_num[t], test_name[t],
                 (errs == 0) ? "passed" : "failed", errs);
    endtask

    initial begin
        int total_errors;
        reset          = 1'b1;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        read_tests();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        total_errors = tb_errors + checker_inst.error_count;
        $display("tests run %0d, tests failed %0d, errors %0d",
                 n_tests, failed_tests, total_errors);
        if (total_errors == 0 && n_tests > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb/pipeline_tests.txt ====
# test <number> <name> | prog <word index hex> <instruction hex>
# store <byte address hex> <expected value hex>, in the order they leave the core
test 1 forwarding
prog 00 24010005
prog 01 24220003
prog 02 00221821
prog 03 00612023
prog 04 ac030000
prog 05 ac040004
prog 06 1000ffff
store 00000000 0000000d
store 00000004 00000008
test 2 load_use
prog 00 24010064
prog 01 ac010008
prog 02 8c020008
prog 03 00411821
prog 04 ac03000c
prog 05 1000ffff
store 00000008 00000064
store 0000000c 000000c8
test 3 branches
prog 00 24010001
prog 01 24020002
prog 02 10210001
prog 03 ac010010
prog 04 14220001
prog 05 ac020014
prog 06 10220001
prog 07 ac020018
prog 08 14210001
prog 09 ac01001c
prog 0a 1000ffff
store 00000018 00000002
store 0000001c 00000001
test 4 logic_shift
prog 00 3c011234
prog 01 34218001
prog 02 3022ff00
prog 03 00011900
prog 04 00012202
prog 05 00222826
prog 06 2406ffff
prog 07 00c0382a
prog 08 ac010020
prog 09 ac020024
prog 0a ac030028
prog 0b ac04002c
prog 0c ac050030
prog 0d ac060034
prog 0e ac070038
prog 0f 1000ffff
store 00000020 12348001
store 00000024 00008000
store 00000028 23480010
store 0000002c 00123480
store 00000030 12340001
store 00000034 ffffffff
store 00000038 00000001
test 5 register_zero
prog 00 24000007
prog 01 00000821
prog 02 ac000040
prog 03 ac010044
prog 04 1000ffff
store 00000040 00000000
store 00000044 00000000
test 6 reset_restart
prog 00 2401002a
prog 01 ac010048
prog 02 1000ffff
store 00000048 0000002a

// ==== project.f ====
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/gpr_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/hazard_unit.sv
hdl/mem_stage.sv
hdl/pipeline_top.sv
tb/pipeline_checker.sv
tb/pipeline_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -sv
LINT_FLAGS = --lint-only --timing -sv
TOP        = pipeline_tb
FILELIST   = project.f
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F -x "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
